// File: src/ifetch_settings.svh
`ifndef IFETCH_SETTINGS_SVH
`define IFETCH_SETTINGS_SVH

// ----------------------------------------
// Fetch front end sizing
// ----------------------------------------

// Byte address width
`define IF_ADDR_W 32

// Instruction and memory word width
`define IF_WORD_W 32

// Cache index width, 16 one-word lines
`define IC_INDEX_BITS 4

// Fetch queue entries
`define IFQ_DEPTH 4

`endif

// File: src/bus_pkg.sv
`default_nettype none

`include "ifetch_settings.svh"

package bus_pkg;

    // Byte address and instruction word
    typedef logic [`IF_ADDR_W-1:0] addr_t;
    typedef logic [`IF_WORD_W-1:0] word_t;

    // Fetch request, pc stage to cache
    typedef struct packed {
        addr_t pc;
    } fetch_req_t;

    // Fetch result, cache to queue and queue to decoder
    typedef struct packed {
        addr_t pc;
        word_t instr;
    } fetch_rsp_t;

    // Refill request on the memory port
    typedef struct packed {
        addr_t addr;
    } mem_req_t;

endpackage

`default_nettype wire

// File: src/cache_pkg.sv
`default_nettype none

`include "ifetch_settings.svh"

package cache_pkg;

    // Word offset below the index
    localparam int IC_OFFSET_BITS = 2;
    localparam int IC_TAG_W = `IF_ADDR_W - `IC_INDEX_BITS - IC_OFFSET_BITS;

    typedef logic [IC_TAG_W-1:0] tag_t;
    typedef logic [`IC_INDEX_BITS-1:0] index_t;

    // Refill sequence, lookup also holds hit responses
    typedef enum logic [1:0] {
        IC_LOOKUP,
        IC_REQ,
        IC_RELEASE,
        IC_RESPOND
    } ic_state_t;

endpackage

`default_nettype wire

// File: src/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_settings.svh"

module pc_gen (
    input  wire                  clock,
    input  wire                  reset,
    input  wire                  run,
    input  wire                  redirect,
    input  wire bus_pkg::addr_t  redirect_pc,
    input  wire                  req_ready,
    output logic                 req_valid,
    output bus_pkg::fetch_req_t  req
);

    import bus_pkg::*;

    // Next fetch address, always word aligned
    addr_t pc;

    assign req.pc = pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc        <= '0;
            req_valid <= 1'b0;
        end else begin
            if (req_valid && req_ready) begin
                // Step to the next word, keep going while run holds
                pc        <= pc + addr_t'(4);
                req_valid <= run;
            end else if (!req_valid) begin
                // Idle, redirect allowed here only
                if (redirect) begin
                    pc <= {redirect_pc[`IF_ADDR_W-1:2], 2'b00};
                end
                req_valid <= run;
            end
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Stalled request keeps its address until the cache takes it
    a_req_stable: assert property (
        @(posedge clock) disable iff (reset)
        req_valid && !req_ready |=> req_valid && $stable(req)
    );

endmodule

`default_nettype wire

// File: src/icache.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_settings.svh"

module icache (
    input  wire                  clock,
    input  wire                  reset,
    input  wire                  flush,
    input  wire                  req_valid,
    input  wire bus_pkg::fetch_req_t req,
    output logic                 req_ready,
    output logic                 rsp_valid,
    input  wire                  rsp_ready,
    output bus_pkg::fetch_rsp_t  rsp,
    output logic                 mem_req,
    output bus_pkg::mem_req_t    mem_addr,
    input  wire                  mem_ack,
    input  wire bus_pkg::word_t  mem_rdata
);

    import bus_pkg::*;
    import cache_pkg::*;

    localparam int LINES = 1 << `IC_INDEX_BITS;

    // ----------------------------------------
    // Line storage
    // ----------------------------------------

    word_t             data_mem [LINES];
    tag_t              tag_mem  [LINES];
    logic [LINES-1:0]  line_valid;

    // Request and response holding
    ic_state_t state;
    addr_t     pc_q;
    logic      pending;
    logic      flush_hold;
    word_t     rsp_word;

    // Lookup of the held pc
    tag_t      req_tag;
    index_t    req_index;
    logic      hit;
    logic      do_flush;

    assign req_tag   = pc_q[`IF_ADDR_W-1 -: IC_TAG_W];
    assign req_index = pc_q[IC_OFFSET_BITS +: `IC_INDEX_BITS];
    assign hit       = line_valid[req_index] && (tag_mem[req_index] == req_tag);

    // Invalidate only between refills
    assign do_flush  = (state == IC_LOOKUP) && (flush || flush_hold);

    // One request at a time, none while a result waits
    assign req_ready = (state == IC_LOOKUP) && !pending && !rsp_valid;

    assign rsp.pc        = pc_q;
    assign rsp.instr     = rsp_word;
    assign mem_addr.addr = pc_q;

    // ----------------------------------------
    // Control
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= IC_LOOKUP;
            pending    <= 1'b0;
            rsp_valid  <= 1'b0;
            mem_req    <= 1'b0;
            flush_hold <= 1'b0;
            line_valid <= '0;
        end else begin
            if (rsp_valid && rsp_ready) begin
                rsp_valid <= 1'b0;
            end

            // Fence during a refill waits for lookup
            if (do_flush) begin
                line_valid <= '0;
                flush_hold <= 1'b0;
            end else if (flush) begin
                flush_hold <= 1'b1;
            end

            case (state)
                IC_LOOKUP: begin
                    if (pending) begin
                        if (hit) begin
                            rsp_valid <= 1'b1;
                            pending   <= 1'b0;
                        end else if (!mem_ack) begin
                            // Previous handshake fully closed
                            mem_req <= 1'b1;
                            pending <= 1'b0;
                            state   <= IC_REQ;
                        end
                    end else if (req_valid && req_ready) begin
                        pending <= 1'b1;
                    end
                end
                IC_REQ: begin
                    if (mem_ack) begin
                        mem_req               <= 1'b0;
                        line_valid[req_index] <= 1'b1;
                        state                 <= IC_RELEASE;
                    end
                end
                IC_RELEASE: begin
                    // Refill done once memory drops ack
                    if (!mem_ack) begin
                        rsp_valid <= 1'b1;
                        state     <= IC_RESPOND;
                    end
                end
                IC_RESPOND: begin
                    if (rsp_ready) begin
                        state <= IC_LOOKUP;
                    end
                end
                default: state <= IC_LOOKUP;
            endcase
        end
    end

    // ----------------------------------------
    // Payload and line write
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (req_valid && req_ready) begin
            pc_q <= req.pc;
        end
        if (state == IC_LOOKUP && pending && hit) begin
            rsp_word <= data_mem[req_index];
        end
        if (state == IC_REQ && mem_ack) begin
            // Refilled word goes to the line and straight out
            rsp_word             <= mem_rdata;
            data_mem[req_index]  <= mem_rdata;
            tag_mem[req_index]   <= req_tag;
        end
    end

    // ----------------------------------------
    // Memory port checks
    // ----------------------------------------

    // Request held until memory answers
    a_req_hold: assert property (
        @(posedge clock) disable iff (reset)
        mem_req && !mem_ack |=> mem_req
    );

    // Request never seen rising over a high ack
    a_req_after_ack: assert property (
        @(posedge clock) disable iff (reset)
        $rose(mem_req) |-> !mem_ack
    );

endmodule

`default_nettype wire

// File: src/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_settings.svh"

module fetch_queue (
    input  wire                  clock,
    input  wire                  reset,
    input  wire                  rsp_valid,
    output logic                 rsp_ready,
    input  wire bus_pkg::fetch_rsp_t rsp,
    output logic                 out_valid,
    input  wire                  out_ready,
    output bus_pkg::fetch_rsp_t  out,
    output logic                 empty
);

    import bus_pkg::*;

    localparam int DEPTH = `IFQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] count_t;

    fetch_rsp_t buffer [DEPTH];
    ptr_t       rd_ptr;
    ptr_t       wr_ptr;
    count_t     count;
    logic       full;
    logic       push;
    logic       pop;

    // Wrap for any depth, not only powers of two
    function automatic ptr_t next_ptr(input ptr_t p);
        if (p == ptr_t'(DEPTH - 1)) begin
            return '0;
        end
        return p + ptr_t'(1);
    endfunction

    assign full      = (count == count_t'(DEPTH));
    assign empty     = (count == '0);
    assign rsp_ready = !full;
    assign out_valid = !empty;
    assign push      = rsp_valid && rsp_ready;
    assign pop       = out_valid && out_ready;

    // Head entry shown directly
    assign out = buffer[rd_ptr];

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            buffer[wr_ptr] <= rsp;
        end
    end

    // Never more entries than slots
    a_no_push_full: assert property (
        @(posedge clock) disable iff (reset)
        count <= count_t'(DEPTH)
    );

endmodule

`default_nettype wire

// File: src/ifetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_settings.svh"

module ifetch_top (
    input  wire                  clock,
    input  wire                  reset,
    input  wire                  run,
    input  wire                  redirect,
    input  wire bus_pkg::addr_t  redirect_pc,
    input  wire                  flush,
    output logic                 out_valid,
    input  wire                  out_ready,
    output bus_pkg::fetch_rsp_t  out,
    output logic                 mem_req,
    output bus_pkg::mem_req_t    mem_addr,
    input  wire                  mem_ack,
    input  wire bus_pkg::word_t  mem_rdata,
    output logic                 busy
);

    import bus_pkg::*;

    // pc stage to cache
    logic       pc_req_valid;
    logic       pc_req_ready;
    fetch_req_t pc_req;

    // Cache to queue
    logic       ic_rsp_valid;
    logic       ic_rsp_ready;
    fetch_rsp_t ic_rsp;

    logic       q_empty;

    pc_gen u_pc_gen (
        .clock       (clock),
        .reset       (reset),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .req_ready   (pc_req_ready),
        .req_valid   (pc_req_valid),
        .req         (pc_req)
    );

    icache u_icache (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .req_valid (pc_req_valid),
        .req       (pc_req),
        .req_ready (pc_req_ready),
        .rsp_valid (ic_rsp_valid),
        .rsp_ready (ic_rsp_ready),
        .rsp       (ic_rsp),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    fetch_queue u_fetch_queue (
        .clock     (clock),
        .reset     (reset),
        .rsp_valid (ic_rsp_valid),
        .rsp_ready (ic_rsp_ready),
        .rsp       (ic_rsp),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out),
        .empty     (q_empty)
    );

    // Cache not ready also covers its held lookup and the ack release
    assign busy = pc_req_valid | !pc_req_ready | mem_req | !q_empty;

endmodule

`default_nettype wire

// File: tb/tb_ifetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_settings.svh"

module tb_ifetch;

    import bus_pkg::*;

    localparam addr_t PATTERN    = 32'h5a5a_0000;
    localparam int    LINES      = 1 << `IC_INDEX_BITS;
    localparam int    WAIT_LIMIT = 4000;
    localparam int    NUM_TESTS  = 6;

    // One table row per fetch run
    typedef struct {
        string name;
        addr_t start;
        int    count;
        bit    flush_first;
        int    refills;
    } test_t;

    // DUT inputs, all start at a known value
    logic       clock       = 1'b0;
    logic       reset       = 1'b1;
    logic       run         = 1'b0;
    logic       redirect    = 1'b0;
    addr_t      redirect_pc = '0;
    logic       flush       = 1'b0;
    logic       out_ready   = 1'b0;
    logic       mem_ack     = 1'b0;
    word_t      mem_rdata   = '0;

    // DUT outputs
    logic       out_valid;
    fetch_rsp_t fetch_out;
    logic       mem_req;
    mem_req_t   mem_addr;
    logic       busy;

    // Random patterns, filled once after seeding
    bit         ready_bits [1024];
    int         ack_delays [256];
    int         cycle_count = 0;

    // Run state shared with the monitors
    test_t      tests [NUM_TESTS];
    string      cur_name = "reset_state";
    addr_t      exp_pc = '0;
    addr_t      win_lo = '0;
    addr_t      win_hi = '0;
    int         taken = 0;
    int         win_refills = 0;
    int         model_misses = 0;
    int         mon_errors = 0;
    int         errors = 0;
    int         tests_failed = 0;
    bit         aborted = 1'b0;

    // Direct-mapped reference, one word per line
    addr_t      model_tag [LINES];
    logic [LINES-1:0] model_valid = '0;

    ifetch_top u_ifetch_top (
        .clock       (clock),
        .reset       (reset),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .flush       (flush),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out         (fetch_out),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .busy        (busy)
    );

    always #2 clock = ~clock;

    function automatic test_t make_test(input string name, input addr_t start,
                                        input int count, input bit flush_first,
                                        input int refills);
        test_t t;
        t.name        = name;
        t.start       = start;
        t.count       = count;
        t.flush_first = flush_first;
        t.refills     = refills;
        return t;
    endfunction

    // Lookup in the reference, fills the line, returns 1 on a miss
    function automatic bit model_access(input addr_t pc);
        int    idx;
        addr_t line_tag;
        idx      = int'(pc[`IC_INDEX_BITS+1:2]);
        line_tag = pc >> (`IC_INDEX_BITS + 2);
        model_access   = !(model_valid[idx] && model_tag[idx] == line_tag);
        model_valid[idx] = 1'b1;
        model_tag[idx]   = line_tag;
    endfunction

    // ----------------------------------------
    // Decoder side
    // ----------------------------------------

    // Back-pressure, low about 30% of cycles
    always @(posedge clock) begin
        out_ready   <= ready_bits[cycle_count % 1024];
        cycle_count <= cycle_count + 1;
    end

    // Every result checked, surplus ones too
    always @(posedge clock) begin
        if (!reset && out_valid && out_ready) begin
            if (fetch_out.pc !== exp_pc) begin
                $display("FAILED %s pc expected %h actual %h", cur_name, exp_pc,
                         fetch_out.pc);
                mon_errors = mon_errors + 1;
            end
            if (fetch_out.instr !== (exp_pc ^ PATTERN)) begin
                $display("FAILED %s instr at %h expected %h actual %h", cur_name,
                         exp_pc, exp_pc ^ PATTERN, fetch_out.instr);
                mon_errors = mon_errors + 1;
            end
            if (model_access(exp_pc) && exp_pc >= win_lo && exp_pc < win_hi) begin
                model_misses <= model_misses + 1;
            end
            exp_pc <= exp_pc + addr_t'(4);
            taken  <= taken + 1;
        end
    end

    // ----------------------------------------
    // Memory responder, four-phase
    // ----------------------------------------

    int   ack_wait_left = 0;
    bit   ack_waiting   = 1'b0;
    int   refill_seq    = 0;
    logic mem_req_q     = 1'b0;

    always @(posedge clock) begin
        if (reset) begin
            mem_ack     <= 1'b0;
            ack_waiting <= 1'b0;
        end else if (mem_ack) begin
            // Release once the cache has dropped its request
            if (!mem_req) begin
                mem_ack <= 1'b0;
            end
        end else if (ack_waiting) begin
            if (ack_wait_left == 0) begin
                mem_ack     <= 1'b1;
                mem_rdata   <= mem_addr.addr ^ PATTERN;
                ack_waiting <= 1'b0;
            end else begin
                ack_wait_left <= ack_wait_left - 1;
            end
        end else if (mem_req) begin
            ack_wait_left <= ack_delays[refill_seq % 256];
            ack_waiting   <= 1'b1;
            refill_seq    <= refill_seq + 1;
        end
    end

    // Refills counted on the rising request, inside the test window only
    always @(posedge clock) begin
        mem_req_q <= mem_req;
        if (mem_req && !mem_req_q && mem_addr.addr >= win_lo && mem_addr.addr < win_hi) begin
            win_refills <= win_refills + 1;
        end
    end

    // ----------------------------------------
    // Waits, each bounded
    // ----------------------------------------

    task automatic wait_for_outputs(input int want, output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(posedge clock);
            ok     = (taken >= want);
            cycles = cycles + 1;
        end
        if (!ok) begin
            $display("Timed out waiting for %0d fetch results in %s, got %0d",
                     want, cur_name, taken);
        end
    endtask

    task automatic wait_for_idle(output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(posedge clock);
            ok     = !busy;
            cycles = cycles + 1;
        end
        if (!ok) begin
            $display("Timed out waiting for the fetch unit to go idle in %s", cur_name);
        end
    endtask

    task automatic run_test(input test_t tc);
        bit ok;
        int exp_refills;
        int err_before;
        err_before = errors + mon_errors;
        cur_name   = tc.name;
        if (tc.flush_first) begin
            @(posedge clock);
            flush <= 1'b1;
            @(posedge clock);
            flush <= 1'b0;
            model_valid = '0;
        end
        @(posedge clock);
        exp_pc       <= tc.start;
        taken        <= 0;
        win_refills  <= 0;
        model_misses <= 0;
        win_lo       <= tc.start;
        win_hi       <= tc.start + addr_t'(4 * tc.count);
        redirect     <= 1'b1;
        redirect_pc  <= tc.start;
        @(posedge clock);
        redirect <= 1'b0;
        run      <= 1'b1;
        wait_for_outputs(tc.count, ok);
        run <= 1'b0;
        if (ok) begin
            wait_for_idle(ok);
        end
        if (!ok) begin
            aborted = 1'b1;
        end else begin
            // Negative table entry defers to the reference model
            exp_refills = (tc.refills >= 0) ? tc.refills : model_misses;
            if (win_refills != exp_refills) begin
                $display("FAILED %s refills expected %0d actual %0d", tc.name,
                         exp_refills, win_refills);
                errors = errors + 1;
            end
        end
        if (errors + mon_errors != err_before || !ok) begin
            tests_failed = tests_failed + 1;
        end
        $display("test %-16s %0d results, %0d refills, %s", tc.name, taken,
                 win_refills, (errors + mon_errors == err_before && ok) ? "ok" : "failed");
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        void'($urandom(32'he9a9));
        for (int i = 0; i < 1024; i++) begin
            ready_bits[i] = ($urandom % 100) >= 30;
        end
        for (int i = 0; i < 256; i++) begin
            ack_delays[i] = $urandom % 6;
        end

        tests[0] = make_test("cold_fetch", 32'h100, 8, 1'b0, 8);
        tests[1] = make_test("warm_refetch", 32'h100, 8, 1'b0, 0);
        tests[2] = make_test("conflict_evict", 32'h140, 8, 1'b0, 8);
        tests[3] = make_test("conflict_return", 32'h100, 8, 1'b0, 8);
        tests[4] = make_test("flush_refetch", 32'h100, 8, 1'b1, 8);
        tests[5] = make_test("backpressure_40", 32'h200, 40, 1'b1, -1);

        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        @(posedge clock);

        // Quiet pipeline before run is raised
        if (out_valid !== 1'b0 || mem_req !== 1'b0 || busy !== 1'b0) begin
            $display("FAILED reset_state out_valid/mem_req/busy expected 000 actual %b%b%b",
                     out_valid, mem_req, busy);
            errors       = errors + 1;
            tests_failed = tests_failed + 1;
        end
        $display("test %-16s %s", "reset_state", (errors == 0) ? "ok" : "failed");

        for (int t = 0; t < NUM_TESTS && !aborted; t++) begin
            run_test(tests[t]);
        end

        $display("summary: %0d of %0d tests failed, %0d check errors%s", tests_failed,
                 NUM_TESTS + 1, errors + mon_errors, aborted ? ", run aborted" : "");
        if (aborted || errors + mon_errors != 0) begin
            $display(">>> FAIL");
        end else begin
            $display(">>> PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ifetch.f
+incdir+src
src/bus_pkg.sv
src/cache_pkg.sv
src/pc_gen.sv
src/icache.sv
src/fetch_queue.sv
src/ifetch_top.sv
tb/tb_ifetch.sv
